/* source/mixer_pkg.sv */
package mixer_pkg;

    // Datapath widths
    parameter int SAMPLE_W  = 16;
    parameter int GAIN_W    = 16;
    parameter int INSTR_W   = 32;
    parameter int ACC_W     = 40;
    parameter int PRODUCT_W = 32;
    parameter int SLOT_W    = 4;
    parameter int OPCODE_W  = 5;

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [GAIN_W-1:0]    gain_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [PRODUCT_W-1:0] product_t;
    typedef logic [SLOT_W-1:0]    slot_t;

    // Z clears the accumulator first, N negates the gain
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOOP    = 5'd0,
        OP_CAPTURE = 5'd1,
        OP_SAVE    = 5'd2,
        OP_MAC     = 5'd8,
        OP_MACZ    = 5'd9,
        OP_MACN    = 5'd10,
        OP_MACNZ   = 5'd11,
        OP_HALT    = 5'd15
    } opcode_t;

    // Returned by capture code 7
    parameter logic [31:0] CAPTURE_MAGIC = 32'h1234_5678;

endpackage

/* source/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 16
) (
    input  logic              ck,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

    // Read returns the old word when both ports hit the same address
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* source/delay_pipe.sv */
`timescale 1ns/1ps

module delay_pipe #(
    parameter int LENGTH = 2
) (
    input  logic ck,
    input  logic reset,
    input  logic din,
    output logic dout
);

    logic [LENGTH-1:0] stages;

    always_ff @(posedge ck) begin
        if (reset) begin
            stages <= '0;
        end else begin
            stages[0] <= din;
            for (int i = 1; i < LENGTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[LENGTH-1];

endmodule

/* source/mix_datapath.sv */
`timescale 1ns/1ps

module mix_datapath #(
    parameter int FRAME_W = 4
) (
    input  logic                 ck,
    input  logic                 reset,
    input  mixer_pkg::sample_t   sample_data,
    input  mixer_pkg::gain_t     gain,
    input  logic                 subtract,
    input  logic                 acc_en,
    input  logic                 acc_clear,
    input  logic                 shift_en,
    input  logic [FRAME_W-1:0]   shift,
    output mixer_pkg::acc_t      acc_out,
    output mixer_pkg::product_t  product,
    output mixer_pkg::sample_t   mix_out
);

    logic                                  sample_neg;
    mixer_pkg::sample_t                    magnitude;
    logic                                  do_sub;
    mixer_pkg::acc_t                       acc_base;
    logic signed [mixer_pkg::ACC_W-1:0]    shifted;
    mixer_pkg::sample_t                    saturated;

    // Negative samples become magnitudes, the sign moves to the adder
    assign sample_neg = sample_data[mixer_pkg::SAMPLE_W-1];
    assign magnitude  = sample_neg ? (~sample_data + 1'b1) : sample_data;

    assign product = mixer_pkg::product_t'(magnitude) * mixer_pkg::product_t'(gain);

    // Subtract when opcode sign and sample sign differ
    assign do_sub   = subtract ^ sample_neg;
    assign acc_base = acc_clear ? '0 : acc_out;

    always_ff @(posedge ck) begin
        if (reset) begin
            acc_out <= '0;
        end else if (acc_en) begin
            if (do_sub) begin
                acc_out <= acc_base - mixer_pkg::acc_t'(product);
            end else begin
                acc_out <= acc_base + mixer_pkg::acc_t'(product);
            end
        end
    end

    // Arithmetic shift then clamp into 16 bits
    assign shifted = $signed(acc_out) >>> shift;

    always_comb begin
        if (shifted > 40'sd32767) begin
            saturated = 16'h7FFF;
        end else if (shifted < -40'sd32768) begin
            saturated = 16'h8000;
        end else begin
            saturated = shifted[mixer_pkg::SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge ck) begin
        if (shift_en) begin
            mix_out <= saturated;
        end
    end

    // Clear and enable come from separate pipes in the sequencer
    a_clear_needs_en: assert property (
        @(posedge ck) disable iff (reset) acc_clear |-> acc_en
    );

endmodule

/* source/sequencer.sv */
`timescale 1ns/1ps

module sequencer #(
    parameter int CHAN_W  = 4,
    parameter int FRAME_W = 4,
    parameter int CODE_W  = 8
) (
    input  logic                        ck,
    input  logic                        reset,
    input  logic                        run,
    input  logic [FRAME_W-1:0]          frame,
    input  mixer_pkg::instr_t           coef_data,
    input  mixer_pkg::sample_t          sample_data,
    output logic [CODE_W-1:0]           coef_addr,
    output logic [CHAN_W+FRAME_W-1:0]   sample_raddr,
    output logic                        out_we,
    output mixer_pkg::slot_t            out_waddr,
    output mixer_pkg::sample_t          out_wdata,
    output logic                        done,
    output logic                        error,
    output logic [31:0]                 capture_out
);

    localparam int SAMPLE_AW = CHAN_W + FRAME_W;
    localparam int OP_W      = 16 - CHAN_W - FRAME_W;

    logic                     flush;
    logic                     fetch_ok;
    logic [OP_W-1:0]          op_field;
    logic [FRAME_W-1:0]       offset;
    logic [CHAN_W-1:0]        chan;
    mixer_pkg::gain_t         gain;
    mixer_pkg::opcode_t       opcode;
    logic                     op_known;
    logic                     halted;
    logic                     dec_mac;
    logic                     dec_clear;
    logic                     dec_neg;
    logic                     dec_save;
    logic                     dec_halt;
    logic                     dec_capture;
    logic                     dec_unknown;
    logic [FRAME_W-1:0]       ring_idx;
    logic [SAMPLE_AW-1:0]     sample_addr_d;
    mixer_pkg::gain_t         gain_d1;
    mixer_pkg::gain_t         gain_d2;
    logic                     sub_d1;
    logic                     sub_d2;
    logic [FRAME_W-1:0]       shift_d1;
    logic [FRAME_W-1:0]       shift_d2;
    logic [FRAME_W-1:0]       shift_d3;
    mixer_pkg::slot_t         slot_d3;
    logic                     acc_en;
    logic                     acc_clear;
    logic                     shift_en;
    mixer_pkg::acc_t          acc_out;
    mixer_pkg::product_t      product;

    // Dropping run empties the whole pipeline
    assign flush = reset || !run;

    // Fetch stage
    always_ff @(posedge ck) begin
        if (flush) begin
            coef_addr <= '0;
            fetch_ok  <= 1'b0;
        end else begin
            if (!done) begin
                coef_addr <= coef_addr + 1'b1;
            end
            // Word 0 is never executed
            fetch_ok <= (coef_addr != '0);
        end
    end

    // Instruction latch
    always_ff @(posedge ck) begin
        if (flush) begin
            op_field <= '0;
        end else if (fetch_ok && !halted && !error) begin
            op_field <= coef_data[31 -: OP_W];
        end else begin
            op_field <= '0;
        end
    end

    always_ff @(posedge ck) begin
        if (fetch_ok) begin
            gain   <= coef_data[15:0];
            chan   <= coef_data[16 +: CHAN_W];
            offset <= coef_data[16 + CHAN_W +: FRAME_W];
        end
    end

    // Decode
    assign opcode   = mixer_pkg::opcode_t'(op_field[mixer_pkg::OPCODE_W-1:0]);
    assign op_known = (op_field >> mixer_pkg::OPCODE_W) == '0;

    always_comb begin
        dec_mac     = 1'b0;
        dec_clear   = 1'b0;
        dec_neg     = 1'b0;
        dec_save    = 1'b0;
        dec_halt    = 1'b0;
        dec_capture = 1'b0;
        dec_unknown = 1'b0;
        if (run && !halted && !error) begin
            if (!op_known) begin
                dec_unknown = 1'b1;
            end else begin
                case (opcode)
                    mixer_pkg::OP_NOOP: ;
                    mixer_pkg::OP_CAPTURE: dec_capture = 1'b1;
                    mixer_pkg::OP_SAVE: dec_save = 1'b1;
                    mixer_pkg::OP_MAC: dec_mac = 1'b1;
                    mixer_pkg::OP_MACZ: begin
                        dec_mac   = 1'b1;
                        dec_clear = 1'b1;
                    end
                    mixer_pkg::OP_MACN: begin
                        dec_mac = 1'b1;
                        dec_neg = 1'b1;
                    end
                    mixer_pkg::OP_MACNZ: begin
                        dec_mac   = 1'b1;
                        dec_clear = 1'b1;
                        dec_neg   = 1'b1;
                    end
                    mixer_pkg::OP_HALT: dec_halt = 1'b1;
                    default: dec_unknown = 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge ck) begin
        if (flush) begin
            halted <= 1'b0;
            error  <= 1'b0;
        end else begin
            if (dec_halt) begin
                halted <= 1'b1;
            end
            if (dec_unknown) begin
                error <= 1'b1;
            end
        end
    end

    // Channel ring address, frame plus offset wraps
    assign ring_idx = frame + offset;

    always_ff @(posedge ck) begin
        sample_raddr  <= {chan, ring_idx};
        sample_addr_d <= sample_raddr;
    end

    // Align fields with the datapath stages
    always_ff @(posedge ck) begin
        gain_d1   <= gain;
        gain_d2   <= gain_d1;
        sub_d1    <= dec_neg;
        sub_d2    <= sub_d1;
        shift_d1  <= offset;
        shift_d2  <= shift_d1;
        shift_d3  <= shift_d2;
        slot_d3   <= gain_d2[mixer_pkg::SLOT_W-1:0];
        out_waddr <= slot_d3;
    end

    delay_pipe #(.LENGTH(2)) i_acc_en_pipe (
        .ck(ck), .reset(flush), .din(dec_mac), .dout(acc_en)
    );

    delay_pipe #(.LENGTH(2)) i_acc_clear_pipe (
        .ck(ck), .reset(flush), .din(dec_clear), .dout(acc_clear)
    );

    delay_pipe #(.LENGTH(3)) i_shift_en_pipe (
        .ck(ck), .reset(flush), .din(dec_save), .dout(shift_en)
    );

    delay_pipe #(.LENGTH(2)) i_done_pipe (
        .ck(ck), .reset(flush), .din(halted), .dout(done)
    );

    mix_datapath #(.FRAME_W(FRAME_W)) i_mix_datapath (
        .ck          (ck),
        .reset       (reset),
        .sample_data (sample_data),
        .gain        (gain_d2),
        .subtract    (sub_d2),
        .acc_en      (acc_en),
        .acc_clear   (acc_clear),
        .shift_en    (shift_en),
        .shift       (shift_d3),
        .acc_out     (acc_out),
        .product     (product),
        .mix_out     (out_wdata)
    );

    // Output write, suppressed once an error is pending
    always_ff @(posedge ck) begin
        if (flush) begin
            out_we <= 1'b0;
        end else begin
            out_we <= shift_en && !error && !dec_unknown;
        end
    end

    // Debug capture, code taken from the offset field
    always_ff @(posedge ck) begin
        if (reset) begin
            capture_out <= '0;
        end else if (dec_capture) begin
            case (offset)
                0: capture_out <= coef_data;
                1: capture_out <= {sample_data, 16'(sample_addr_d)};
                2: capture_out <= {gain_d2, sample_data};
                3: capture_out <= product;
                5: capture_out <= acc_out[31:0];
                6: capture_out <= 32'({out_waddr, out_wdata});
                7: capture_out <= mixer_pkg::CAPTURE_MAGIC;
                default: capture_out <= capture_out;
            endcase
        end
    end

    a_pc_holds_when_done: assert property (
        @(posedge ck) disable iff (reset)
        (run && $past(run) && $past(done)) |-> $stable(coef_addr)
    );

    a_no_write_on_error: assert property (
        @(posedge ck) disable iff (reset) error |-> !out_we
    );

endmodule

/* source/mixer_top.sv */
`timescale 1ns/1ps

module mixer_top #(
    parameter int CHAN_W  = 4,
    parameter int FRAME_W = 4,
    parameter int CODE_W  = 8
) (
    input  logic                        ck,
    input  logic                        reset,
    input  logic                        run,
    input  logic [FRAME_W-1:0]          frame,
    input  logic                        coef_we,
    input  logic [CODE_W-1:0]           coef_waddr,
    input  mixer_pkg::instr_t           coef_wdata,
    input  logic                        sample_we,
    input  logic [CHAN_W+FRAME_W-1:0]   sample_waddr,
    input  mixer_pkg::sample_t          sample_wdata,
    input  mixer_pkg::slot_t            out_raddr,
    output mixer_pkg::sample_t          out_rdata,
    output logic                        done,
    output logic                        error,
    output logic [31:0]                 capture_out
);

    logic [CODE_W-1:0]          coef_addr;
    mixer_pkg::instr_t          coef_data;
    logic [CHAN_W+FRAME_W-1:0]  sample_raddr;
    mixer_pkg::sample_t         sample_data;
    logic                       out_we;
    mixer_pkg::slot_t           out_waddr;
    mixer_pkg::sample_t         out_wdata;

    // Program memory
    dual_port_ram #(
        .ADDR_W(CODE_W),
        .DATA_W(mixer_pkg::INSTR_W)
    ) i_coef_ram (
        .ck(ck), .we(coef_we), .waddr(coef_waddr), .wdata(coef_wdata),
        .raddr(coef_addr), .rdata(coef_data)
    );

    // One ring of samples per channel
    dual_port_ram #(
        .ADDR_W(CHAN_W + FRAME_W),
        .DATA_W(mixer_pkg::SAMPLE_W)
    ) i_sample_ram (
        .ck(ck), .we(sample_we), .waddr(sample_waddr), .wdata(sample_wdata),
        .raddr(sample_raddr), .rdata(sample_data)
    );

    // Output slots, read back by the host
    dual_port_ram #(
        .ADDR_W(mixer_pkg::SLOT_W),
        .DATA_W(mixer_pkg::SAMPLE_W)
    ) i_out_ram (
        .ck(ck), .we(out_we), .waddr(out_waddr), .wdata(out_wdata),
        .raddr(out_raddr), .rdata(out_rdata)
    );

    sequencer #(
        .CHAN_W(CHAN_W),
        .FRAME_W(FRAME_W),
        .CODE_W(CODE_W)
    ) i_sequencer (
        .ck           (ck),
        .reset        (reset),
        .run          (run),
        .frame        (frame),
        .coef_data    (coef_data),
        .sample_data  (sample_data),
        .coef_addr    (coef_addr),
        .sample_raddr (sample_raddr),
        .out_we       (out_we),
        .out_waddr    (out_waddr),
        .out_wdata    (out_wdata),
        .done         (done),
        .error        (error),
        .capture_out  (capture_out)
    );

endmodule

/* bench/mixer_tb.sv */
`timescale 1ns/1ps

module mixer_tb;

    localparam int CHAN_W        = 4;
    localparam int FRAME_W       = 4;
    localparam int CODE_W        = 8;
    localparam int SAMPLE_AW     = CHAN_W + FRAME_W;
    localparam int MAX_TESTS     = 16;
    localparam int MAX_ITEMS     = 256;
    localparam int RESET_CYCLES  = 16;
    // Fetch, decode, save latency and the output write
    localparam int RETIRE_CYCLES = 8;
    localparam int WAIT_MARGIN   = 16;

    logic                  ck;
    logic                  reset;
    logic                  run;
    logic [FRAME_W-1:0]    frame;
    logic                  coef_we;
    logic [CODE_W-1:0]     coef_waddr;
    mixer_pkg::instr_t     coef_wdata;
    logic                  sample_we;
    logic [SAMPLE_AW-1:0]  sample_waddr;
    mixer_pkg::sample_t    sample_wdata;
    mixer_pkg::slot_t      out_raddr;
    mixer_pkg::sample_t    out_rdata;
    logic                  done;
    logic                  error;
    logic [31:0]           capture_out;

    // Test table
    logic [8*20-1:0]       test_name   [MAX_TESTS];
    logic [FRAME_W-1:0]    test_frame  [MAX_TESTS];
    logic                  exp_done    [MAX_TESTS];
    logic                  exp_error   [MAX_TESTS];
    logic [31:0]           exp_capture [MAX_TESTS];
    int                    prog_first  [MAX_TESTS];
    int                    prog_len    [MAX_TESTS];
    int                    samp_first  [MAX_TESTS];
    int                    samp_len    [MAX_TESTS];
    int                    slot_first  [MAX_TESTS];
    int                    slot_len    [MAX_TESTS];
    mixer_pkg::instr_t     prog_word   [MAX_ITEMS];
    logic [SAMPLE_AW-1:0]  samp_addr   [MAX_ITEMS];
    mixer_pkg::sample_t    samp_value  [MAX_ITEMS];
    mixer_pkg::slot_t      slot_addr   [MAX_ITEMS];
    mixer_pkg::sample_t    slot_value  [MAX_ITEMS];

    int                    test_count;
    int                    prog_total;
    int                    samp_total;
    int                    slot_total;
    int                    error_count;
    int                    check_count;
    int                    watchdog_cycles;
    logic                  stim_ready;
    logic [8*20-1:0]       cur_name;

    mixer_top #(.CHAN_W(CHAN_W), .FRAME_W(FRAME_W), .CODE_W(CODE_W)) i_mixer_top (
        .ck(ck), .reset(reset), .run(run), .frame(frame),
        .coef_we(coef_we), .coef_waddr(coef_waddr), .coef_wdata(coef_wdata),
        .sample_we(sample_we), .sample_waddr(sample_waddr), .sample_wdata(sample_wdata),
        .out_raddr(out_raddr), .out_rdata(out_rdata),
        .done(done), .error(error), .capture_out(capture_out)
    );

    initial begin
        ck = 1'b0;
        forever begin
            #2 ck = ~ck;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAILED %0s %0s: expected %h, actual %h", cur_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic read_stimulus();
        int              fd;
        int              n;
        int              count;
        int              t;
        logic [8*20-1:0] key;
        logic [8*20-1:0] name;
        logic [8*128-1:0] rest;
        logic [31:0]     a;
        logic [31:0]     v;
        logic [31:0]     d;
        logic [31:0]     e;
        logic            finished;
        fd = $fopen("bench/mixer_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file bench/mixer_stim.txt");
            error_count++;
        end else begin
            finished = 1'b0;
            while (!finished) begin
                key = '0;
                n = $fscanf(fd, "%s", key);
                t = test_count - 1;
                if (n != 1) begin
                    finished = 1'b1;
                end else if (key == "#") begin
                    n = $fgets(rest, fd);
                end else if (key == "test") begin
                    name = '0;
                    n = $fscanf(fd, "%s %h %h %h %h", name, a, d, e, v);
                    test_name[test_count]   = name;
                    test_frame[test_count]  = a[FRAME_W-1:0];
                    exp_done[test_count]    = d[0];
                    exp_error[test_count]   = e[0];
                    exp_capture[test_count] = v;
                    prog_first[test_count]  = prog_total;
                    samp_first[test_count]  = samp_total;
                    slot_first[test_count]  = slot_total;
                    prog_len[test_count]    = 0;
                    samp_len[test_count]    = 0;
                    slot_len[test_count]    = 0;
                    test_count++;
                end else if (key == "prog") begin
                    n = $fscanf(fd, "%d", count);
                    for (int i = 0; i < count; i++) begin
                        n = $fscanf(fd, "%h", v);
                        prog_word[prog_total] = v;
                        prog_total++;
                        prog_len[t]++;
                    end
                end else if (key == "samp") begin
                    n = $fscanf(fd, "%d", count);
                    for (int i = 0; i < count; i++) begin
                        n = $fscanf(fd, "%h %h", a, v);
                        samp_addr[samp_total]  = a[SAMPLE_AW-1:0];
                        samp_value[samp_total] = v[15:0];
                        samp_total++;
                        samp_len[t]++;
                    end
                end else if (key == "check") begin
                    n = $fscanf(fd, "%d", count);
                    for (int i = 0; i < count; i++) begin
                        n = $fscanf(fd, "%h %h", a, v);
                        slot_addr[slot_total]  = a[3:0];
                        slot_value[slot_total] = v[15:0];
                        slot_total++;
                        slot_len[t]++;
                    end
                end else begin
                    $display("Unknown keyword %0s in the stimulus file", key);
                    error_count++;
                    finished = 1'b1;
                end
            end
            $fclose(fd);
            if (test_count == 0) begin
                $display("No tests found in the stimulus file");
                error_count++;
            end
        end
    endtask

    task automatic load_memories(input int t);
        // Word 0 is reserved, the program starts at word 1
        @(posedge ck);
        #1;
        coef_we    = 1'b1;
        coef_waddr = '0;
        coef_wdata = '0;
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge ck);
            #1;
            coef_waddr = CODE_W'(i + 1);
            coef_wdata = prog_word[prog_first[t] + i];
        end
        @(posedge ck);
        #1;
        coef_we = 1'b0;
        for (int i = 0; i < samp_len[t]; i++) begin
            sample_we    = 1'b1;
            sample_waddr = samp_addr[samp_first[t] + i];
            sample_wdata = samp_value[samp_first[t] + i];
            @(posedge ck);
            #1;
        end
        sample_we = 1'b0;
    endtask

    task automatic execute_program(input int t);
        int   cycles;
        logic seen;
        @(posedge ck);
        #1;
        frame  = test_frame[t];
        run    = 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < prog_len[t] + WAIT_MARGIN) begin
            @(posedge ck);
            #1;
            cycles++;
            seen = done || error;
        end
        if (!seen) begin
            $display("Test %0s: neither done nor error rose within %0d cycles", cur_name, cycles);
            error_count++;
        end else begin
            check_value("done", 32'(exp_done[t]), 32'(done));
            check_value("error", 32'(exp_error[t]), 32'(error));
        end
        // Let any save still in flight reach the output memory
        while (cycles < prog_len[t] + RETIRE_CYCLES) begin
            @(posedge ck);
            #1;
            cycles++;
        end
        run = 1'b0;
    endtask

    task automatic check_slots(input int t);
        int k;
        for (int i = 0; i < slot_len[t]; i++) begin
            k = slot_first[t] + i;
            @(posedge ck);
            #1;
            out_raddr = slot_addr[k];
            @(posedge ck);
            #1;
            check_value($sformatf("slot %0d", slot_addr[k]), 32'(slot_value[k]),
                        32'(out_rdata));
        end
    endtask

    initial begin : main_flow
        reset        = 1'b1;
        run          = 1'b0;
        frame        = '0;
        coef_we      = 1'b0;
        coef_waddr   = '0;
        coef_wdata   = '0;
        sample_we    = 1'b0;
        sample_waddr = '0;
        sample_wdata = '0;
        out_raddr    = '0;
        stim_ready   = 1'b0;
        test_count   = 0;
        prog_total   = 0;
        samp_total   = 0;
        slot_total   = 0;
        error_count  = 0;
        check_count  = 0;
        read_stimulus();
        // Budget grows with every load, run and read-back
        watchdog_cycles = RESET_CYCLES + 64;
        for (int t = 0; t < test_count; t++) begin
            watchdog_cycles += 2 * prog_len[t] + samp_len[t] + 2 * slot_len[t] + 24;
        end
        stim_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge ck);
        #1;
        reset = 1'b0;
        for (int t = 0; t < test_count; t++) begin
            cur_name = test_name[t];
            load_memories(t);
            execute_program(t);
            check_slots(t);
            check_value("capture", exp_capture[t], capture_out);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (stim_ready === 1'b1);
        repeat (watchdog_cycles) @(posedge ck);
        $display("Timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bench/mixer_stim.txt */
# Test line columns are name frame done error capture
# Then prog n words, samp n addr data pairs, check n slot value pairs. Counts decimal, rest hex
test single_mac 0 1 0 00000000
prog 8 09310010 00000000 00000000 00000000 02200000 09410100 00000000 00000000
prog 5 00000000 02300001 00000000 00000000 0F000000
samp 2 13 0123 14 FF00
check 2 0 048C 1 E000
test mac_chain 2 1 0 00000000
prog 8 09020003 08120004 0A220002 0A320005 00000000 00000000 00000000 02000002
prog 8 0B020007 08220001 00000000 00000000 00000000 02000003 00000000 00000000
prog 1 0F000000
samp 4 22 0064 23 FFCE 24 00C8 25 FF9C
check 2 2 00C8 3 FE0C
test ring_frame_e e 1 0 00000000
prog 8 09330001 08230010 00000000 00000000 00000000 02000004 00000000 00000000
prog 1 0F000000
samp 4 30 0005 31 0011 37 0003 38 0022
check 1 4 0061
test ring_frame_5 5 1 0 00000000
prog 8 09330001 08230010 00000000 00000000 00000000 02000004 00000000 00000000
prog 1 0F000000
check 1 4 0052
test saturate 0 1 0 00000000
prog 8 0904FFFF 00000000 00000000 00000000 02100006 09148000 00000000 00000000
prog 5 00000000 02400007 00000000 00000000 0F000000
samp 2 40 7FFF 41 8000
check 2 6 7FFF 7 8000
test halt_keeps_slots 0 1 0 00000000
prog 8 09010002 00000000 00000000 00000000 02000008 00000000 00000000 0F000000
prog 1 02000000
samp 1 10 0040
check 5 8 0080 0 048C 1 E000 2 00C8 6 7FFF
test unknown_opcode 0 0 1 00000000
prog 8 09010003 00000000 00000000 00000000 02000009 00000000 00000000 00000000
prog 8 00000000 05000000 09010005 00000000 00000000 00000000 02000008 0F000000
check 2 9 00C0 8 0080
test capture_acc 0 1 0 0003FF9C
prog 8 09011000 0A220001 00000000 00000000 00000000 01500000 00000000 00000000
prog 1 0F000000
check 1 9 00C0
test capture_magic 0 1 0 12345678
prog 3 01700000 00000000 0F000000
check 1 3 FE0C

/* files.f */
source/mixer_pkg.sv
source/dual_port_ram.sv
source/delay_pipe.sv
source/mix_datapath.sv
source/sequencer.sv
source/mixer_top.sv
bench/mixer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the mixer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mixer_tb \
    -f files.f --Mdir obj_dir -o Vmixer_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmixer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
